//--- hw/hrdrst_clk_pkg.sv
//////////////////////////////////////////////////
// Hard-reset clock control shared types
// Scan control struct and CSR map
//////////////////////////////////////////////////
`default_nettype none

package hrdrst_clk_pkg;

    // Scan controls, active high after pin inversion
    typedef struct packed {
        logic scan_mode;       // Scan / ATPG mode
        logic scan_shift;      // Shift phase of scan
        logic occ_enable;      // Fast capture pulses allowed
        logic user_clk_sel;    // Capture on user clock, else test clock
        logic fastclk_bypass;  // Boundary-scan fast clock bypass
    } dft_ctrl_t;

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////
    localparam int CSR_ADDR_W = 2;
    localparam int CSR_DATA_W = 8;

    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_CTRL   = CSR_ADDR_W'(0);
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_STATUS = CSR_ADDR_W'(1);

    // Control register fields
    typedef struct packed {
        logic [CSR_DATA_W-2:0] reserved;  // Reads as zero
        logic                  osc_clk_scg_en;  // Set stops the osc clocks
    } csr_ctrl_t;

endpackage

`default_nettype wire

//--- hw/occ_pulse_ctrl.sv
//////////////////////////////////////////////////
// On-chip clock controller
// Test clock while shifting, counted fast pulses on capture
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module occ_pulse_ctrl #(
    parameter int PULSE_COUNT = 2  // Capture pulses, 1 to 15
) (
    input  wire logic user_clk,
    input  wire logic test_clk,
    input  wire logic reset,
    input  wire logic user_clk_sel,
    input  wire logic scan_enable,
    input  wire logic occ_enable,
    input  wire logic atpg_mode,
    output logic      out_clk
);

    localparam int CNT_W = $clog2(PULSE_COUNT + 1);

    logic [2:0]       se_sync;       // Two sync stages and one for the edge
    logic             capture_start;
    logic             armed;
    logic [CNT_W-1:0] pulse_cnt;
    logic             pulse_en_lat;
    logic             pulse_clk;
    logic             capture_clk;

    // scan_enable into the user clock domain
    always_ff @(posedge user_clk) begin
        if (reset) begin
            se_sync <= '0;
        end else begin
            se_sync <= {se_sync[1:0], scan_enable};
        end
    end

    assign capture_start = se_sync[2] & ~se_sync[1];  // Shift just ended

    //////////////////////////////////////////////////
    // Pulse counter
    //////////////////////////////////////////////////
    always_ff @(posedge user_clk) begin
        if (reset) begin
            armed     <= 1'b0;
            pulse_cnt <= '0;
        end else if (se_sync[1]) begin  // Back in shift, drop any capture
            armed     <= 1'b0;
            pulse_cnt <= '0;
        end else if (armed) begin
            if (pulse_cnt == CNT_W'(PULSE_COUNT - 1)) begin
                armed     <= 1'b0;  // Last pulse passing now
                pulse_cnt <= '0;
            end else begin
                pulse_cnt <= pulse_cnt + 1'b1;
            end
        end else if (capture_start && occ_enable && atpg_mode) begin
            armed <= 1'b1;
        end
    end

    // Enable only changes while user_clk is low
    always_latch begin
        if (!user_clk) begin
            pulse_en_lat <= armed;
        end
    end

    assign pulse_clk = user_clk & pulse_en_lat;

    // Slow capture on the test clock when the user clock is not selected
    assign capture_clk = user_clk_sel ? pulse_clk : test_clk;

    // Glitch-safe select, both sources low at shift-to-capture
    assign out_clk = !atpg_mode  ? user_clk :
                     scan_enable ? test_clk : capture_clk;

    a_pulse_cnt_max: assert property (
        @(posedge user_clk) disable iff (reset) pulse_cnt <= PULSE_COUNT
    );

endmodule

`default_nettype wire

//--- hw/clk_path_sel.sv
//////////////////////////////////////////////////
// Oscillator clock path, mission/OCC select and gate
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module clk_path_sel (
    input  wire logic mission_clk,
    input  wire logic occ_clk,
    input  wire logic use_occ,
    input  wire logic gate_en,
    output logic      clk_ungated,
    output logic      clk_gated
);

    logic sel_clk;
    logic en_lat;

    // Behavioural stand-in for the clock mux cell
    assign sel_clk     = use_occ ? occ_clk : mission_clk;
    assign clk_ungated = sel_clk;

    //////////////////////////////////////////////////
    // Latch-based clock gate
    //////////////////////////////////////////////////
    always_latch begin
        if (!sel_clk) begin
            en_lat <= gate_en;  // Transparent in the low phase
        end
    end

    assign clk_gated = sel_clk & en_lat;  // Whole pulses only

    // Latch has tracked the enable through the low phase
    a_gate_en_stable: assert property (
        @(posedge sel_clk) en_lat == gate_en
    );

endmodule

`default_nettype wire

//--- hw/hrdrst_csr.sv
//////////////////////////////////////////////////
// Hard-reset CSR block
// Clock gate enable and synchronized scan status
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module hrdrst_csr (
    input  wire logic                                 csr_clk_in,
    input  wire logic                                 reset,
    input  wire logic                                 csr_wr,
    input  wire logic                                 csr_rd,
    input  wire logic [hrdrst_clk_pkg::CSR_ADDR_W-1:0] csr_addr,
    input  wire logic [hrdrst_clk_pkg::CSR_DATA_W-1:0] csr_wdata,
    input  wire hrdrst_clk_pkg::dft_ctrl_t            dft,
    output logic [hrdrst_clk_pkg::CSR_DATA_W-1:0]     csr_rdata,
    output hrdrst_clk_pkg::csr_ctrl_t                 ctrl
);

    localparam int DW = hrdrst_clk_pkg::CSR_DATA_W;

    logic          scg_en_q;
    logic [2:0]    status_meta;
    logic [2:0]    status_sync;
    logic [DW-1:0] rd_mux;

    // Scan status, two-flop synchronizer
    always_ff @(posedge csr_clk_in) begin
        if (reset) begin
            status_meta <= '0;
            status_sync <= '0;
        end else begin
            status_meta <= {dft.occ_enable, dft.scan_shift, dft.scan_mode};
            status_sync <= status_meta;
        end
    end

    //////////////////////////////////////////////////
    // Write and read
    //////////////////////////////////////////////////
    always_ff @(posedge csr_clk_in) begin
        if (reset) begin
            scg_en_q <= 1'b0;  // Gating off
        end else if (csr_wr && csr_addr == hrdrst_clk_pkg::CSR_ADDR_CTRL) begin
            scg_en_q <= csr_wdata[0];
        end
    end

    assign ctrl = '{reserved: '0, osc_clk_scg_en: scg_en_q};

    always_comb begin
        case (csr_addr)
            hrdrst_clk_pkg::CSR_ADDR_CTRL:   rd_mux = ctrl;
            hrdrst_clk_pkg::CSR_ADDR_STATUS: rd_mux = DW'(status_sync);
            default:                         rd_mux = '0;  // Unmapped
        endcase
    end

    always_ff @(posedge csr_clk_in) begin
        if (reset) begin
            csr_rdata <= '0;
        end else if (csr_rd) begin
            csr_rdata <= rd_mux;  // Held until the next read
        end
    end

    a_no_wr_rd: assert property (
        @(posedge csr_clk_in) disable iff (reset) !(csr_wr && csr_rd)
    );

endmodule

`default_nettype wire

//--- hw/hrdrst_clkctl.sv
//////////////////////////////////////////////////
// Hard-reset clock control
// Register clock muxes and the rx/tx oscillator paths
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module hrdrst_clkctl #(
    parameter int PULSE_COUNT = 2
) (
    input  wire logic                      rx_osc_clk_in,
    input  wire logic                      tx_osc_clk_in,
    input  wire logic                      csr_clk_in,
    input  wire logic                      scan_shift_clk,
    input  wire logic                      scan_user_clk,
    input  wire logic                      reset,
    input  wire hrdrst_clk_pkg::dft_ctrl_t dft,
    input  wire hrdrst_clk_pkg::csr_ctrl_t ctrl,
    output logic                           rx_osc_clk,
    output logic                           tx_osc_clk,
    output logic                           rx_osc_clk_ungated,
    output logic                           tx_osc_clk_ungated,
    output logic                           csr_clk,
    output logic                           csr_clk_n,
    output logic                           csr_clk_out
);

    logic scg_bypass;
    logic osc_clk_en;
    logic atpg_mode;
    logic csr_clk_in_n;
    logic rx_occ_clk;
    logic tx_occ_clk;

    // DFT decode
    assign scg_bypass = dft.fastclk_bypass | dft.scan_mode;  // Also picks the OCC path
    assign osc_clk_en = scg_bypass | ~ctrl.osc_clk_scg_en;
    assign atpg_mode  = dft.scan_mode;

    assign csr_clk_out = csr_clk_in;  // Feedthrough

    //////////////////////////////////////////////////
    // Register clocks
    //////////////////////////////////////////////////
    assign csr_clk_in_n = ~csr_clk_in;
    assign csr_clk      = dft.scan_mode ? scan_shift_clk  : csr_clk_in;
    assign csr_clk_n    = dft.scan_mode ? ~scan_shift_clk : csr_clk_in_n;

    //////////////////////////////////////////////////
    // Oscillator paths
    //////////////////////////////////////////////////
    occ_pulse_ctrl #(.PULSE_COUNT(PULSE_COUNT)) i_occ_rx (
        .user_clk     (scan_user_clk),
        .test_clk     (scan_shift_clk),
        .reset        (reset),
        .user_clk_sel (dft.user_clk_sel),
        .scan_enable  (dft.scan_shift),
        .occ_enable   (dft.occ_enable),
        .atpg_mode    (atpg_mode),
        .out_clk      (rx_occ_clk)
    );

    clk_path_sel i_path_rx (
        .mission_clk (rx_osc_clk_in),
        .occ_clk     (rx_occ_clk),
        .use_occ     (scg_bypass),
        .gate_en     (osc_clk_en),
        .clk_ungated (rx_osc_clk_ungated),
        .clk_gated   (rx_osc_clk)
    );

    occ_pulse_ctrl #(.PULSE_COUNT(PULSE_COUNT)) i_occ_tx (
        .user_clk     (scan_user_clk),
        .test_clk     (scan_shift_clk),
        .reset        (reset),
        .user_clk_sel (dft.user_clk_sel),
        .scan_enable  (dft.scan_shift),
        .occ_enable   (dft.occ_enable),
        .atpg_mode    (atpg_mode),
        .out_clk      (tx_occ_clk)
    );

    clk_path_sel i_path_tx (
        .mission_clk (tx_osc_clk_in),
        .occ_clk     (tx_occ_clk),
        .use_occ     (scg_bypass),
        .gate_en     (osc_clk_en),
        .clk_ungated (tx_osc_clk_ungated),
        .clk_gated   (tx_osc_clk)
    );

endmodule

`default_nettype wire

//--- hw/hrdrst_clk_top.sv
//////////////////////////////////////////////////
// Hard-reset clock top, CSR block and clock control
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module hrdrst_clk_top #(
    parameter int PULSE_COUNT = 2
) (
    input  wire logic                                  reset,
    input  wire logic                                  rx_osc_clk_in,
    input  wire logic                                  tx_osc_clk_in,
    input  wire logic                                  csr_clk_in,
    input  wire logic                                  scan_shift_clk,
    input  wire logic                                  scan_user_clk,
    input  wire logic                                  scan_mode_n,
    input  wire logic                                  scan_shift_n,
    input  wire logic                                  clk_sel_n,
    input  wire logic                                  fastclk_bypass_n,
    input  wire logic                                  occ_enable,
    input  wire logic                                  csr_wr,
    input  wire logic                                  csr_rd,
    input  wire logic [hrdrst_clk_pkg::CSR_ADDR_W-1:0] csr_addr,
    input  wire logic [hrdrst_clk_pkg::CSR_DATA_W-1:0] csr_wdata,
    output logic [hrdrst_clk_pkg::CSR_DATA_W-1:0]      csr_rdata,
    output logic                                       rx_osc_clk,
    output logic                                       tx_osc_clk,
    output logic                                       rx_osc_clk_ungated,
    output logic                                       tx_osc_clk_ungated,
    output logic                                       csr_clk,
    output logic                                       csr_clk_n,
    output logic                                       csr_clk_out
);

    hrdrst_clk_pkg::dft_ctrl_t dft;
    hrdrst_clk_pkg::csr_ctrl_t ctrl;

    // Pins are active low, inverted once here
    assign dft = '{
        scan_mode:      ~scan_mode_n,
        scan_shift:     ~scan_shift_n,
        occ_enable:     occ_enable,
        user_clk_sel:   ~clk_sel_n,
        fastclk_bypass: ~fastclk_bypass_n
    };

    hrdrst_csr i_csr (
        .csr_clk_in (csr_clk_in),
        .reset      (reset),
        .csr_wr     (csr_wr),
        .csr_rd     (csr_rd),
        .csr_addr   (csr_addr),
        .csr_wdata  (csr_wdata),
        .dft        (dft),
        .csr_rdata  (csr_rdata),
        .ctrl       (ctrl)
    );

    hrdrst_clkctl #(.PULSE_COUNT(PULSE_COUNT)) i_clkctl (
        .rx_osc_clk_in      (rx_osc_clk_in),
        .tx_osc_clk_in      (tx_osc_clk_in),
        .csr_clk_in         (csr_clk_in),
        .scan_shift_clk     (scan_shift_clk),
        .scan_user_clk      (scan_user_clk),
        .reset              (reset),
        .dft                (dft),
        .ctrl               (ctrl),
        .rx_osc_clk         (rx_osc_clk),
        .tx_osc_clk         (tx_osc_clk),
        .rx_osc_clk_ungated (rx_osc_clk_ungated),
        .tx_osc_clk_ungated (tx_osc_clk_ungated),
        .csr_clk            (csr_clk),
        .csr_clk_n          (csr_clk_n),
        .csr_clk_out        (csr_clk_out)
    );

endmodule

`default_nettype wire

//--- test/hrdrst_clk_checker.sv
//////////////////////////////////////////////////
// Testbench checker, edge counts and CSR reads
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module hrdrst_clk_checker (
    input wire logic                                  reset,
    input wire logic [10:0]                           clks,       // Sources, then outputs
    input wire logic                                  csr_clk_n,
    input wire logic [hrdrst_clk_pkg::CSR_DATA_W-1:0] csr_rdata
);

    // Bit positions in clks
    typedef enum int {
        RX_IN, TX_IN, USER, SHIFT, CSR_IN, RX, TX, RX_UG, TX_UG, CSR, CSR_OUT
    } clk_idx_e;

    localparam int NCLK = CSR_OUT + 1;

    int   cnt [NCLK];
    logic counting     = 1'b0;
    int   check_cnt    = 0;
    int   mismatch_cnt = 0;
    int   other_cnt    = 0;

    // Rising edges per clock while a window is open
    for (genvar i = 0; i < NCLK; i = i + 1) begin : g_edge
        always @(posedge clks[i]) begin
            if (counting) begin
                cnt[i] = cnt[i] + 1;
            end
        end
    end

    task automatic compare(input string test, input string sig, input int exp, input int act,
                           input int tol);
        check_cnt = check_cnt + 1;
        if (act > exp + tol || act < exp - tol) begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("MISMATCH %s %s expected %0d actual %0d", test, sig, exp, act);
        end
    endtask

    task automatic open_window();
        for (int k = 0; k < NCLK; k++) begin
            cnt[k] = 0;
        end
        counting = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Window checks
    //////////////////////////////////////////////////
    task automatic check_window(input string test, input logic use_occ, input logic gate_open,
                                input logic scan);
        int src_rx;
        int src_tx;
        counting = 1'b0;
        src_rx = use_occ ? cnt[USER] : cnt[RX_IN];  // OCC passes the user clock here
        src_tx = use_occ ? cnt[USER] : cnt[TX_IN];
        compare(test, "csr_clk", scan ? cnt[SHIFT] : cnt[CSR_IN], cnt[CSR], 1);
        compare(test, "csr_clk_out", cnt[CSR_IN], cnt[CSR_OUT], 1);
        if (!scan) begin
            compare(test, "rx_osc_clk_ungated", src_rx, cnt[RX_UG], 1);
            compare(test, "tx_osc_clk_ungated", src_tx, cnt[TX_UG], 1);
            // A closed gate allows no edge at all
            compare(test, "rx_osc_clk", gate_open ? src_rx : 0, cnt[RX], gate_open ? 1 : 0);
            compare(test, "tx_osc_clk", gate_open ? src_tx : 0, cnt[TX], gate_open ? 1 : 0);
        end
    endtask

    task automatic check_pulses(input string test, input int exp);
        counting = 1'b0;
        compare(test, "rx_osc_clk", exp, cnt[RX], 0);
        compare(test, "tx_osc_clk", exp, cnt[TX], 0);
    endtask

    task automatic check_rdata(input string test, input int exp);
        compare(test, "csr_rdata", exp, int'(csr_rdata), 0);
    endtask

    // Inverse register clock never high with the register clock
    always @(posedge clks[CSR]) begin
        #1;
        if (!reset && clks[CSR] && csr_clk_n) begin
            other_cnt = other_cnt + 1;
            $display("ERROR csr_clk_n is high together with csr_clk at %0t ns", $time);
        end
    end

endmodule

`default_nettype wire

//--- test/tb_hrdrst_clk.sv
//////////////////////////////////////////////////
// Testbench for the hard-reset clock top
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_hrdrst_clk;

    localparam int          PULSE_COUNT = 2;
    localparam int          TEST_CYCLES = 2000;  // Upper estimate of all tests
    localparam int          MAX_CYCLES  = 2 * TEST_CYCLES;
    localparam int          WIN         = 80;    // Window, csr_clk cycles
    localparam logic [31:0] SEED        = 32'h75a6_770d;

    // All clock edges land on even ns, drives on odd ns
    logic rx_osc_clk_in  = 1'b0;
    logic tx_osc_clk_in  = 1'b0;
    logic csr_clk_in     = 1'b0;
    logic scan_shift_clk = 1'b0;
    logic scan_user_clk  = 1'b0;

    initial forever #6 rx_osc_clk_in = ~rx_osc_clk_in;
    initial forever #10 tx_osc_clk_in = ~tx_osc_clk_in;
    initial forever #2 csr_clk_in = ~csr_clk_in;
    initial forever #8 scan_shift_clk = ~scan_shift_clk;
    initial forever #4 scan_user_clk = ~scan_user_clk;

    logic                                  reset;
    logic                                  scan_mode_n;
    logic                                  scan_shift_n;
    logic                                  clk_sel_n;
    logic                                  fastclk_bypass_n;
    logic                                  occ_enable;
    logic                                  csr_wr;
    logic                                  csr_rd;
    logic [hrdrst_clk_pkg::CSR_ADDR_W-1:0] csr_addr;
    logic [hrdrst_clk_pkg::CSR_DATA_W-1:0] csr_wdata;
    logic [hrdrst_clk_pkg::CSR_DATA_W-1:0] csr_rdata;
    logic [hrdrst_clk_pkg::CSR_DATA_W-1:0] wdata;
    wire                                   rx_osc_clk;
    wire                                   tx_osc_clk;
    wire                                   rx_osc_clk_ungated;
    wire                                   tx_osc_clk_ungated;
    wire                                   csr_clk;
    wire                                   csr_clk_n;
    wire                                   csr_clk_out;
    logic                                  model_scg_en;  // Model of the gate enable bit
    int                                    cycle_cnt = 0;

    hrdrst_clk_top #(.PULSE_COUNT(PULSE_COUNT)) i_dut (.*);

    hrdrst_clk_checker i_chk (
        .reset     (reset),
        .clks      ({csr_clk_out, csr_clk, tx_osc_clk_ungated, rx_osc_clk_ungated, tx_osc_clk,
                     rx_osc_clk, csr_clk_in, scan_shift_clk, scan_user_clk, tx_osc_clk_in,
                     rx_osc_clk_in}),
        .csr_clk_n (csr_clk_n),
        .csr_rdata (csr_rdata)
    );

    //////////////////////////////////////////////////
    // Model and drive tasks
    //////////////////////////////////////////////////
    function automatic logic occ_path_selected();
        return !fastclk_bypass_n || !scan_mode_n;
    endfunction

    function automatic logic gate_is_open();
        return occ_path_selected() || !model_scg_en;
    endfunction

    task automatic step(input int n);
        repeat (n) @(posedge csr_clk_in);
        #1;
    endtask

    task automatic csr_write(input logic [hrdrst_clk_pkg::CSR_ADDR_W-1:0] addr,
                             input logic [hrdrst_clk_pkg::CSR_DATA_W-1:0] data);
        csr_wr    = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        step(1);
        csr_wr = 1'b0;
        if (addr == hrdrst_clk_pkg::CSR_ADDR_CTRL) begin
            model_scg_en = data[0];  // Reserved bits are dropped
        end
    endtask

    task automatic csr_read(input string test, input logic [hrdrst_clk_pkg::CSR_ADDR_W-1:0] addr,
                            input int exp);
        csr_rd   = 1'b1;
        csr_addr = addr;
        step(1);
        csr_rd = 1'b0;
        i_chk.check_rdata(test, exp);
    endtask

    task automatic measure(input string test);
        step(4);  // Gates and selects settle
        i_chk.open_window();
        step(WIN);
        i_chk.check_window(test, occ_path_selected(), gate_is_open(), !scan_mode_n);
    endtask

    initial begin
        void'($urandom(SEED));
        reset            = 1'b1;
        scan_mode_n      = 1'b1;
        scan_shift_n     = 1'b1;
        clk_sel_n        = 1'b1;
        fastclk_bypass_n = 1'b1;
        occ_enable       = 1'b0;
        csr_wr           = 1'b0;
        csr_rd           = 1'b0;
        csr_addr         = '0;
        csr_wdata        = '0;
        model_scg_en     = 1'b0;
        step(5);
        reset = 1'b0;
        step(2);

        repeat (16) begin
            wdata = $urandom;
            csr_write(hrdrst_clk_pkg::CSR_ADDR_CTRL, wdata);
            csr_read("ctrl readback", hrdrst_clk_pkg::CSR_ADDR_CTRL, model_scg_en);
        end
        csr_write(hrdrst_clk_pkg::CSR_ADDR_CTRL, 8'hff);
        csr_read("ctrl readback", hrdrst_clk_pkg::CSR_ADDR_CTRL, model_scg_en);
        csr_read("unmapped read", 2'd2, 0);  // Held data and ctrl both nonzero here
        csr_read("unmapped read", 2'd3, 0);
        repeat (6) begin
            scan_mode_n  = $urandom_range(0, 1);
            scan_shift_n = $urandom_range(0, 1);
            occ_enable   = $urandom_range(0, 1);
            step(3);  // Status synchronizer latency
            csr_read("status", hrdrst_clk_pkg::CSR_ADDR_STATUS,
                     {occ_enable, !scan_shift_n, !scan_mode_n});
        end

        //////////////////////////////////////////////////
        // Clock selection and gating
        //////////////////////////////////////////////////
        scan_mode_n  = 1'b1;
        scan_shift_n = 1'b1;
        occ_enable   = 1'b0;
        csr_write(hrdrst_clk_pkg::CSR_ADDR_CTRL, 8'h00);
        measure("mission");
        csr_write(hrdrst_clk_pkg::CSR_ADDR_CTRL, 8'h01);
        measure("static gating");
        csr_write(hrdrst_clk_pkg::CSR_ADDR_CTRL, 8'h00);
        measure("gating cleared");
        csr_write(hrdrst_clk_pkg::CSR_ADDR_CTRL, 8'h01);
        fastclk_bypass_n = 1'b0;
        measure("fastclk bypass");
        fastclk_bypass_n = 1'b1;
        csr_write(hrdrst_clk_pkg::CSR_ADDR_CTRL, 8'h00);
        scan_mode_n = 1'b0;
        measure("scan csr_clk");

        // ATPG captures on the user clock, every third one without OCC
        clk_sel_n = 1'b0;
        for (int i = 0; i < 8; i++) begin
            occ_enable   = (i % 3 != 2);
            scan_shift_n = 1'b0;
            step($urandom_range(8, 20));
            scan_shift_n = 1'b1;
            i_chk.open_window();
            step(24);
            i_chk.check_pulses("occ capture", occ_enable ? PULSE_COUNT : 0);
        end

        $display("checks %0d, mismatches %0d, other errors %0d",
                 i_chk.check_cnt, i_chk.mismatch_cnt, i_chk.other_cnt);
        if (i_chk.mismatch_cnt == 0 && i_chk.other_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge csr_clk_in);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("ERROR run did not finish within %0d csr_clk cycles", MAX_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hw/hrdrst_clk_pkg.sv
hw/occ_pulse_ctrl.sv
hw/clk_path_sel.sv
hw/hrdrst_csr.sv
hw/hrdrst_clkctl.sv
hw/hrdrst_clk_top.sv
test/hrdrst_clk_checker.sv
test/tb_hrdrst_clk.sv
